/* compile.f */
+incdir+hw
+incdir+test
hw/vec_mem_pkg.sv
hw/axi_addr_pkg.sv
hw/addrgen_req_if.sv
hw/vinsn_intake.sv
hw/axi_req_gen.sv
hw/lsu_cmd_queue.sv
hw/addr_gen_top.sv
test/tb_addr_gen.sv

/* Makefile */
# Verilator flow for the vector memory address generator

RTL = hw/vec_mem_pkg.sv hw/axi_addr_pkg.sv hw/addrgen_req_if.sv hw/vinsn_intake.sv \
      hw/axi_req_gen.sv hw/lsu_cmd_queue.sv hw/addr_gen_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+hw $(RTL) --top-module addr_gen_top

sim:
	verilator --binary --timing -f compile.f --top-module tb_addr_gen -Mdir obj_dir -o tb_addr_gen
	./obj_dir/tb_addr_gen | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_addr_gen_tasks.svh */
// Testbench helpers for the vector memory address generator
// Random bits, value checks, request driving, bus sampling and the
// expected beat model built from the burst and stride rules

// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
function automatic logic next_rand_bit();
  lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
  return lfsr[0];
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
  end
endtask

//////////////////////////////////////////////////
// Expected beats
//////////////////////////////////////////////////

// Full-width INCR bursts cut at the element end, 256 beats or the page end
task automatic model_burst(input logic [31:0] addr, input int vl, input vew_e ew,
                           input logic ld);
  logic [63:0] a;
  logic [63:0] s;
  logic [63:0] wend;
  logic [63:0] lim;
  int          rem;
  int          used;
  lsu_cmd_t    c;
  a   = {32'd0, addr};
  rem = vl;
  while (rem > 0) begin
    s    = a & ~64'(`ADDRGEN_BUS_BYTES - 1);
    wend = (a + (64'(rem) << ew) - 64'd1) | 64'(`ADDRGEN_BUS_BYTES - 1);
    lim  = s + 64'(`ADDRGEN_MAX_BEATS * `ADDRGEN_BUS_BYTES) - 64'd1;
    if (lim < wend) wend = lim;
    lim  = s | 64'((1 << `ADDRGEN_PAGE_BITS) - 1);
    if (lim < wend) wend = lim;
    c.beat.addr = a[31:0];
    c.beat.len  = 8'((wend - s) >> `ADDRGEN_BUS_SIZE);
    c.beat.size = 3'(`ADDRGEN_BUS_SIZE);
    c.is_load   = ld;
    exp_cmds.push_back(c);
    // Elements covered up to the window end
    used = int'((wend + 64'd1 - a) >> ew);
    rem  = (used >= rem) ? 0 : rem - used;
    a    = wend + 64'd1;
  end
endtask

// One single beat per element stepping by the stride
task automatic model_stride(input logic [31:0] addr, input int vl, input logic [31:0] stride,
                            input vew_e ew, input logic ld);
  lsu_cmd_t c;
  for (int i = 0; i < vl; i++) begin
    c.beat.addr = addr + 32'(i) * stride;
    c.beat.len  = 8'd0;
    c.beat.size = {1'b0, ew};
    c.is_load   = ld;
    exp_cmds.push_back(c);
  end
endtask

//////////////////////////////////////////////////
// Bus sampling
//////////////////////////////////////////////////

// Samples at the falling edge where every signal has settled
task automatic step_cycle();
  lsu_cmd_t c;
  logic     hs;
  @(negedge clk);
  if (ar_valid || aw_valid) valid_seen++;
  hs = (ar_valid && ar_ready) || (aw_valid && aw_ready);
  c.beat    = ar_valid ? ar : aw;
  c.is_load = ar_valid;
  if (hs) begin
    // Queue state as it stands before this edge
    if (c.is_load ? (n_store != 0) : (n_load != 0)) begin
      errors++;
      $display("Beat handshaken while commands of the other direction were queued");
    end
    if (n_load + n_store >= `ADDRGEN_CMD_DEPTH) begin
      errors++;
      $display("Beat handshaken while the command queue was full");
    end
    got_beats.push_back(c);
  end
  // Pop takes effect at the coming edge
  if (cmd_valid && cmd_pop) begin
    got_cmds.push_back(cmd);
    if (cmd.is_load) n_load--;
    else n_store--;
  end
  if (hs && c.is_load) n_load++;
  if (hs && !c.is_load) n_store++;
  if (ack) begin
    ack_seen = 1'b1;
    ack_err  = error;
  end
endtask

task automatic wait_for_ack(input int limit, input logic exp_err);
  int n;
  n = 0;
  while (!ack_seen && n < limit) begin
    step_cycle();
    n++;
  end
  if (ack_seen) begin
    check_value("error_o at ack_o", 32'(ack_err), 32'(exp_err));
  end else begin
    $display("Timed out waiting for ack_o after %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end
endtask

// Pops every queued command
task automatic drain_cmds(input int limit);
  int n;
  n      = 0;
  pop_en = 1'b1;
  while ((n_load + n_store) != 0 && n < limit) begin
    step_cycle();
    n++;
  end
  if ((n_load + n_store) != 0) begin
    $display("Timed out draining the command queue, %0d left", n_load + n_store);
    $display("SIMULATION FAILED");
    $finish;
  end
endtask

// One-cycle request strobe while the intake is idle
task automatic issue_req(input mem_op_e op, input logic [31:0] addr, input logic [15:0] vl,
                         input logic [31:0] stride, input vew_e ew);
  @(posedge clk);
  #1;
  req_valid  = 1'b1;
  req_op     = op;
  req_addr   = addr;
  req_vl     = vl;
  req_stride = stride;
  req_vew    = ew;
  ack_seen   = 1'b0;
  ack_err    = 1'b0;
  step_cycle();
  @(posedge clk);
  #1;
  req_valid = 1'b0;
endtask

task automatic compare_cmd(input string name, input lsu_cmd_t got, input lsu_cmd_t exp);
  check_value({name, ".addr"}, got.beat.addr, exp.beat.addr);
  check_value({name, ".len"}, 32'(got.beat.len), 32'(exp.beat.len));
  check_value({name, ".size"}, 32'(got.beat.size), 32'(exp.beat.size));
  check_value({name, ".is_load"}, 32'(got.is_load), 32'(exp.is_load));
endtask

// Both the bus beats and the popped commands follow the model order
task automatic compare_results(input string tag);
  check_value($sformatf("%s beat count", tag), got_beats.size(), exp_cmds.size());
  check_value($sformatf("%s cmd count", tag), got_cmds.size(), exp_cmds.size());
  foreach (exp_cmds[i]) begin
    if (i < got_beats.size()) begin
      compare_cmd($sformatf("%s ar_o/aw_o[%0d]", tag, i), got_beats[i], exp_cmds[i]);
    end
    if (i < got_cmds.size()) begin
      compare_cmd($sformatf("%s cmd_o[%0d]", tag, i), got_cmds[i], exp_cmds[i]);
    end
  end
endtask

task automatic clear_records();
  exp_cmds.delete();
  got_beats.delete();
  got_cmds.delete();
  valid_seen = 0;
endtask

/* test/tb_addr_gen.sv */
// Testbench for the vector memory address generator
// Directed unit-stride, strided, misaligned, ordering and queue
// back-pressure tests against a model of the beat rules

`timescale 1ns/100ps
`include "addrgen_consts.svh"

module tb_addr_gen;

  import vec_mem_pkg::*;
  import axi_addr_pkg::*;

  logic     clk, rst_n;
  logic     req_valid, store_pending;
  mem_op_e  req_op;
  addr_t    req_addr, req_stride;
  vlen_t    req_vl;
  vew_e     req_vew;
  logic     ack, error;
  ax_beat_t ar, aw;
  logic     ar_valid, ar_ready, aw_valid, aw_ready;
  lsu_cmd_t cmd;
  logic     cmd_valid, cmd_pop;

  logic [31:0] lfsr;
  int          errors, checks, valid_seen;
  // Commands handshaken but not yet popped per direction
  int          n_load, n_store;
  logic        pop_en, ack_seen, ack_err;
  lsu_cmd_t    exp_cmds[$];
  lsu_cmd_t    got_beats[$];
  lsu_cmd_t    got_cmds[$];

  addr_gen_top dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_op_i       (req_op),
    .req_addr_i     (req_addr),
    .req_vl_i       (req_vl),
    .req_stride_i   (req_stride),
    .req_vew_i      (req_vew),
    .ack_o          (ack),
    .error_o        (error),
    .store_pending_i(store_pending),
    .ar_o           (ar),
    .ar_valid_o     (ar_valid),
    .ar_ready_i     (ar_ready),
    .aw_o           (aw),
    .aw_valid_o     (aw_valid),
    .aw_ready_i     (aw_ready),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .cmd_pop_i      (cmd_pop)
  );

  `include "tb_addr_gen_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random AR/AW ready and command pops 1 ns after each rising edge
  initial begin
    ar_ready = 1'b0;
    aw_ready = 1'b0;
    cmd_pop  = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      ar_ready = next_rand_bit();
      aw_ready = next_rand_bit();
      cmd_pop  = next_rand_bit() && pop_en;
    end
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Single burst inside one page
  task automatic test_unit_load();
    clear_records();
    model_burst(32'h1000_0100, 20, EW32, 1'b1);
    issue_req(VLE, 32'h1000_0100, 16'd20, 32'd0, EW32);
    wait_for_ack(200, 1'b0);
    drain_cmds(200);
    compare_results("unit load");
  endtask

  // Cut at the page end, at the 256-beat limit and where both coincide
  task automatic test_page_store();
    clear_records();
    model_burst(32'h2000_0f00, 600, EW64, 1'b0);
    issue_req(VSE, 32'h2000_0f00, 16'd600, 32'd0, EW64);
    wait_for_ack(400, 1'b0);
    drain_cmds(200);
    compare_results("page store");
  endtask

  // Loads then stores, the stores waiting for the loads to drain
  task automatic test_strided();
    clear_records();
    model_stride(32'h3000_0000, 5, 32'h40, EW32, 1'b1);
    issue_req(VLSE, 32'h3000_0000, 16'd5, 32'h40, EW32);
    wait_for_ack(200, 1'b0);
    model_stride(32'h3000_1002, 4, 32'h106, EW16, 1'b0);
    issue_req(VSSE, 32'h3000_1002, 16'd4, 32'h106, EW16);
    wait_for_ack(200, 1'b0);
    drain_cmds(200);
    compare_results("strided");
  endtask

  // Word access on a halfword address
  task automatic test_misaligned();
    clear_records();
    issue_req(VLE, 32'h4000_0002, 16'd4, 32'd0, EW32);
    wait_for_ack(50, 1'b1);
    check_value("ar_valid_o/aw_valid_o cycles before ack_o", valid_seen, 32'd0);
    compare_results("misaligned");
  endtask

  task automatic test_store_pending();
    clear_records();
    @(posedge clk);
    #1;
    store_pending = 1'b1;
    model_burst(32'h5000_0040, 8, EW64, 1'b1);
    issue_req(VLE, 32'h5000_0040, 16'd8, 32'd0, EW64);
    // Request sits in the generator while the store is pending
    repeat (16) step_cycle();
    check_value("ar_valid_o cycles with store_pending_i", valid_seen, 32'd0);
    @(posedge clk);
    #1;
    store_pending = 1'b0;
    wait_for_ack(200, 1'b0);
    drain_cmds(200);
    compare_results("store pending");
  endtask

  // Store behind unpopped load commands
  task automatic test_direction();
    clear_records();
    pop_en = 1'b0;
    model_stride(32'h5000_0000, 3, 32'h20, EW32, 1'b1);
    issue_req(VLSE, 32'h5000_0000, 16'd3, 32'h20, EW32);
    wait_for_ack(200, 1'b0);
    model_stride(32'h5000_1000, 2, 32'h10, EW64, 1'b0);
    valid_seen = 0;
    issue_req(VSSE, 32'h5000_1000, 16'd2, 32'h10, EW64);
    repeat (12) step_cycle();
    check_value("aw_valid_o cycles with loads queued", valid_seen, 32'd0);
    pop_en = 1'b1;
    wait_for_ack(200, 1'b0);
    drain_cmds(200);
    compare_results("direction");
  endtask

  // More beats than queue entries with pops stopped
  task automatic test_backpressure();
    clear_records();
    pop_en = 1'b0;
    model_stride(32'h6000_0000, 8, 32'h8, EW64, 1'b1);
    issue_req(VLSE, 32'h6000_0000, 16'd8, 32'h8, EW64);
    repeat (30) step_cycle();
    if (got_beats.size() > `ADDRGEN_CMD_DEPTH || ack_seen) begin
      errors++;
      $display("More beats than queue entries went out with pops stopped");
    end
    pop_en = 1'b1;
    wait_for_ack(300, 1'b0);
    drain_cmds(200);
    compare_results("backpressure");
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_op        = VLE;
    req_addr      = '0;
    req_vl        = '0;
    req_stride    = '0;
    req_vew       = EW8;
    store_pending = 1'b0;
    lfsr          = 32'h82c;
    errors        = 0;
    checks        = 0;
    valid_seen    = 0;
    n_load        = 0;
    n_store       = 0;
    pop_en        = 1'b1;
    ack_seen      = 1'b0;
    ack_err       = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_unit_load();
    test_page_store();
    test_strided();
    test_misaligned();
    test_store_pending();
    test_direction();
    test_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* hw/addr_gen_top.sv */
// Vector memory address generator top level
// Intake, AR/AW beat generator and load/store command queue

`timescale 1ns/100ps

module addr_gen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Vector memory request
  input  logic                   req_valid_i,
  input  vec_mem_pkg::mem_op_e   req_op_i,
  input  vec_mem_pkg::addr_t     req_addr_i,
  input  vec_mem_pkg::vlen_t     req_vl_i,
  input  vec_mem_pkg::addr_t     req_stride_i,
  input  vec_mem_pkg::vew_e      req_vew_i,
  output logic                   ack_o,
  output logic                   error_o,
  input  logic                   store_pending_i,
  // Address channels
  output axi_addr_pkg::ax_beat_t ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output axi_addr_pkg::ax_beat_t aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Commands to the load/store units
  output axi_addr_pkg::lsu_cmd_t cmd_o,
  output logic                   cmd_valid_o,
  input  logic                   cmd_pop_i
);

  import axi_addr_pkg::*;

  lsu_cmd_t push_cmd;
  logic     cmd_push;
  logic     cmd_full;
  logic     cmd_empty;

  addrgen_req_if req_if ();

  vinsn_intake u_intake (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_vl_i    (req_vl_i),
    .req_stride_i(req_stride_i),
    .req_vew_i   (req_vew_i),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .req_if      (req_if)
  );

  // Head direction feeds the ordering rule
  axi_req_gen u_req_gen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_if            (req_if),
    .store_pending_i   (store_pending_i),
    .ar_o              (ar_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_o              (aw_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i),
    .cmd_push_o        (cmd_push),
    .cmd_o             (push_cmd),
    .cmd_full_i        (cmd_full),
    .cmd_empty_i       (cmd_empty),
    .cmd_head_is_load_i(cmd_o.is_load)
  );

  lsu_cmd_queue u_cmd_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_push),
    .cmd_i  (push_cmd),
    .pop_i  (cmd_pop_i),
    .cmd_o  (cmd_o),
    .full_o (cmd_full),
    .empty_o(cmd_empty)
  );

  assign cmd_valid_o = !cmd_empty;

endmodule

/* hw/lsu_cmd_queue.sv */
// Load/store command queue
// Circular buffer of commands in issue order, drained by the
// load/store units

`timescale 1ns/100ps
`include "addrgen_consts.svh"

module lsu_cmd_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  axi_addr_pkg::lsu_cmd_t cmd_i,
  input  logic                   pop_i,
  output axi_addr_pkg::lsu_cmd_t cmd_o,
  output logic                   full_o,
  output logic                   empty_o
);

  import axi_addr_pkg::*;

  localparam int unsigned depth = `ADDRGEN_CMD_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  lsu_cmd_t            mem_q [depth];
  logic [ptr_w-1:0]    wptr_q, rptr_q;
  logic [cnt_w-1:0]    count_q;
  logic                push_ok;
  logic                pop_ok;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // Head entry
  assign cmd_o = mem_q[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) begin
        wptr_q <= (wptr_q == ptr_w'(depth - 1)) ? '0 : wptr_q + ptr_w'(1);
      end
      if (pop_ok) begin
        rptr_q <= (rptr_q == ptr_w'(depth - 1)) ? '0 : rptr_q + ptr_w'(1);
      end
      // Occupancy moves only when exactly one side acts
      if (push_ok && !pop_ok) begin
        count_q <= count_q + cnt_w'(1);
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - cnt_w'(1);
      end
    end
  end

endmodule

/* hw/axi_req_gen.sv */
// AR/AW beat generator
// Turns a unit-stride request into full-width INCR bursts cut at the
// 256-beat limit and at 4 KiB pages, and a strided request into one
// single-beat access per element, pushing a command per beat

`timescale 1ns/100ps
`include "addrgen_consts.svh"

module axi_req_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  addrgen_req_if.dst             req_if,
  input  logic                   store_pending_i,
  // Read address channel
  output axi_addr_pkg::ax_beat_t ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  // Write address channel
  output axi_addr_pkg::ax_beat_t aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Command queue
  output logic                   cmd_push_o,
  output axi_addr_pkg::lsu_cmd_t cmd_o,
  input  logic                   cmd_full_i,
  input  logic                   cmd_empty_i,
  input  logic                   cmd_head_is_load_i
);

  import vec_mem_pkg::*;
  import axi_addr_pkg::*;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_WAITING,
    GEN_REQUESTING
  } gen_state_e;

  gen_state_e   state_q, state_d;
  addrgen_req_t cur_q, cur_d;
  addr_t        start_q, start_d;
  addr_t        end_q, end_d;
  ax_beat_t     beat;
  addr_t        consumed;
  logic         dir_ok;
  logic         offer;
  logic         fire;

  // Bus-aligned address
  function automatic addr_t bus_align(addr_t addr);
    bus_align = addr & ~addr_t'(`ADDRGEN_BUS_BYTES - 1);
  endfunction

  // Last byte of the next burst window starting at addr
  function automatic addr_t window_end(addr_t addr, vlen_t len, vew_e vew);
    addr_t base;
    addr_t elem_end;
    addr_t burst_end;
    addr_t page_end;
    base      = bus_align(addr);
    // End of the last element rounded up to a full beat
    elem_end  = (addr + (addr_t'(len) << vew) - addr_t'(1)) | addr_t'(`ADDRGEN_BUS_BYTES - 1);
    burst_end = base + addr_t'(`ADDRGEN_MAX_BEATS << `ADDRGEN_BUS_SIZE) - addr_t'(1);
    page_end  = base | addr_t'((1 << `ADDRGEN_PAGE_BITS) - 1);
    window_end = elem_end;
    if (burst_end < window_end) window_end = burst_end;
    if (page_end < window_end) window_end = page_end;
  endfunction

  //////////////////////////////////////////////////
  // Beat formation
  //////////////////////////////////////////////////

  always_comb begin
    beat.addr = cur_q.addr;
    if (cur_q.is_burst) begin
      beat.len  = ax_len_t'((end_q - start_q) >> `ADDRGEN_BUS_SIZE);
      beat.size = ax_size_t'(`ADDRGEN_BUS_SIZE);
    end else begin
      beat.len  = '0;
      beat.size = {1'b0, cur_q.vew};
    end
  end

  // No switch of direction while the other side still has commands queued
  assign dir_ok = cmd_empty_i || (cmd_head_is_load_i == cur_q.is_load);
  assign offer  = (state_q == GEN_REQUESTING) && dir_ok && !cmd_full_i;
  assign fire   = offer && (cur_q.is_load ? ar_ready_i : aw_ready_i);

  assign ar_o       = beat;
  assign aw_o       = beat;
  assign ar_valid_o = offer && cur_q.is_load;
  assign aw_valid_o = offer && !cur_q.is_load;

  // Command mirrors the beat and is pushed on the handshake edge
  assign cmd_o      = '{beat: beat, is_load: cur_q.is_load};
  assign cmd_push_o = fire;

  // Elements covered up to the window end
  assign consumed = (end_q - cur_q.addr + addr_t'(1)) >> cur_q.vew;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    cur_d        = cur_q;
    start_d      = start_q;
    end_d        = end_q;
    req_if.ready = 1'b0;
    case (state_q)
      GEN_IDLE: begin
        if (req_if.valid) begin
          cur_d   = req_if.req;
          start_d = bus_align(req_if.req.addr);
          end_d   = window_end(req_if.req.addr, req_if.req.len, req_if.req.vew);
          state_d = store_pending_i ? GEN_WAITING : GEN_REQUESTING;
        end
      end
      GEN_WAITING: begin
        // Hold off until the core has no store in flight
        if (!store_pending_i) begin
          state_d = GEN_REQUESTING;
        end
      end
      GEN_REQUESTING: begin
        if (fire) begin
          if (cur_q.is_burst) begin
            if (addr_t'(cur_q.len) <= consumed) begin
              cur_d.len = '0;
            end else begin
              cur_d.len = cur_q.len - vlen_t'(consumed);
            end
            // Next burst starts aligned right after this window
            cur_d.addr = end_q + addr_t'(1);
            start_d    = end_q + addr_t'(1);
            end_d      = window_end(end_q + addr_t'(1), cur_d.len, cur_q.vew);
          end else begin
            cur_d.len  = cur_q.len - vlen_t'(1);
            cur_d.addr = cur_q.addr + cur_q.stride;
          end
          // Last beat done
          if (cur_d.len == '0) begin
            req_if.ready = 1'b1;
            state_d      = GEN_IDLE;
          end
        end
      end
      default: state_d = GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GEN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and window registers
  always_ff @(posedge clk_i) begin
    cur_q   <= cur_d;
    start_q <= start_d;
    end_q   <= end_d;
  end

endmodule

/* hw/vinsn_intake.sv */
// Vector memory request intake
// Registers one request at a time, checks base address alignment
// against the element width and hands it to the beat generator,
// then acknowledges it with or without error

`timescale 1ns/100ps

module vinsn_intake (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request from the core
  input  logic                 req_valid_i,
  input  vec_mem_pkg::mem_op_e req_op_i,
  input  vec_mem_pkg::addr_t   req_addr_i,
  input  vec_mem_pkg::vlen_t   req_vl_i,
  input  vec_mem_pkg::addr_t   req_stride_i,
  input  vec_mem_pkg::vew_e    req_vew_i,
  // Completion
  output logic                 ack_o,
  output logic                 error_o,
  // Towards the beat generator
  addrgen_req_if.src           req_if
);

  import vec_mem_pkg::*;

  typedef enum logic [1:0] {
    IN_IDLE,
    IN_CHECK,
    IN_ISSUE
  } in_state_e;

  in_state_e    state_q, state_d;
  addrgen_req_t req_q;
  addr_t        align_mask;
  logic         misaligned;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // Capture only while idle, strobes in other states are dropped
  always_ff @(posedge clk_i) begin
    if (state_q == IN_IDLE && req_valid_i) begin
      req_q.addr     <= req_addr_i;
      req_q.len      <= req_vl_i;
      req_q.stride   <= req_stride_i;
      req_q.vew      <= req_vew_i;
      req_q.is_load  <= (req_op_i == VLE) || (req_op_i == VLSE);
      req_q.is_burst <= (req_op_i == VLE) || (req_op_i == VSE);
    end
  end

  // Base must be a multiple of the element size
  assign align_mask = (addr_t'(1) << req_q.vew) - addr_t'(1);
  assign misaligned = |(req_q.addr & align_mask);

  assign req_if.req   = req_q;
  assign req_if.valid = (state_q == IN_ISSUE);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_o   = 1'b0;
    error_o = 1'b0;
    case (state_q)
      IN_IDLE: begin
        if (req_valid_i) begin
          state_d = IN_CHECK;
        end
      end
      IN_CHECK: begin
        if (misaligned) begin
          // Reject without issuing a single beat
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = IN_IDLE;
        end else if (req_q.len == '0) begin
          // Empty vector, nothing to issue
          ack_o   = 1'b1;
          state_d = IN_IDLE;
        end else begin
          state_d = IN_ISSUE;
        end
      end
      IN_ISSUE: begin
        // Generator signals the last beat
        if (req_if.ready) begin
          ack_o   = 1'b1;
          state_d = IN_IDLE;
        end
      end
      default: state_d = IN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hw/addrgen_req_if.sv */
// Request handoff between intake and beat generator
// The intake holds valid with a stable request until the generator
// returns a one-cycle ready after the last beat handshake

`timescale 1ns/100ps

interface addrgen_req_if;

  // Accepted request, stable while valid is high
  vec_mem_pkg::addrgen_req_t req;
  logic                      valid;

  // Pulses once the final beat of the request has gone out
  logic                      ready;

  // Intake side
  modport src (
    output req,
    output valid,
    input  ready
  );

  // Beat generator side
  modport dst (
    input  req,
    input  valid,
    output ready
  );

endinterface

/* hw/axi_addr_pkg.sv */
// Bus address channel types
// One AR/AW address beat and the matching command that the
// load/store units take from the command queue

`include "addrgen_consts.svh"

package axi_addr_pkg;

  typedef logic [`ADDRGEN_ADDR_W-1:0] ax_addr_t;

  // Burst length minus one, as on the AXI bus
  typedef logic [7:0] ax_len_t;

  // log2 of the bytes moved per beat
  typedef logic [2:0] ax_size_t;

  // Address beat on AR or AW
  typedef struct packed {
    ax_addr_t addr;
    ax_len_t  len;
    ax_size_t size;
  } ax_beat_t;

  // Load/store unit command
  // Same fields as the beat plus the direction
  typedef struct packed {
    ax_beat_t beat;
    logic     is_load;
  } lsu_cmd_t;

endpackage

/* hw/vec_mem_pkg.sv */
// Vector memory instruction types
// Element widths, request kinds and the request record that travels
// from the intake to the bus beat generator

`include "addrgen_consts.svh"

package vec_mem_pkg;

  // Element width, encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Kind of vector memory access
  // Unit-stride load/store and strided load/store
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } mem_op_e;

  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;
  typedef logic [`ADDRGEN_VL_W-1:0]   vlen_t;

  // One accepted request
  // len counts elements still to be requested
  typedef struct packed {
    addr_t addr;
    vlen_t len;
    addr_t stride;
    vew_e  vew;
    logic  is_load;
    // Unit-stride requests become INCR bursts
    logic  is_burst;
  } addrgen_req_t;

endpackage

/* hw/addrgen_consts.svh */
// Vector memory address generator constants
// Bus geometry, burst and page limits, request field widths and
// command queue depth shared by the packages and the RTL blocks

`ifndef ADDRGEN_CONSTS_SVH
`define ADDRGEN_CONSTS_SVH

// Byte address width
`define ADDRGEN_ADDR_W 32

// Data bus is 64 bits wide
`define ADDRGEN_BUS_BYTES 8
// log2 of the bus width in bytes, used as the burst beat size
`define ADDRGEN_BUS_SIZE 3

// Bursts never exceed 256 beats nor cross a 4 KiB page
`define ADDRGEN_MAX_BEATS 256
`define ADDRGEN_PAGE_BITS 12

// Vector length field width
`define ADDRGEN_VL_W 16

// Entries in the load/store command queue
`define ADDRGEN_CMD_DEPTH 4

`endif
